/* Makefile */
# Verilator build and run for the UPI controller testbench
VERILATOR ?= verilator
TOP       ?= tb_upi_mcu
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Regression passed

BIN  := $(BUILD_DIR)/V$(TOP)
SRCS := $(wildcard design/*.sv design/*.svh tb/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* design/upi_config.svh */
/*
 * UPI controller build configuration
 * Memory sizes, machine-cycle divider and debug select width
 */
`ifndef UPI_CONFIG_SVH
`define UPI_CONFIG_SVH

// Program memory address bits, 2 KB
`define UPI_ROM_AW 11

// Data RAM address bits, 256 bytes
`define UPI_RAM_AW 8

// Clock enables per machine cycle
`define UPI_CEN_DIV 3

// Debug selector input width
`define UPI_ST_SEL_W 4

`endif

/* design/upi_data_ram.sv */
/*
 * UPI data RAM
 * 256 bytes, single port, read-during-write gives old data
 */
`timescale 1ns/10ps
`default_nettype none

`include "upi_config.svh"

module upi_data_ram
    import upi_pkg::*;
(
    input  wire           clk,
    input  wire ram_req_t req_i,
    output logic [7:0]    q_o
);

    logic [7:0] mem [2**`UPI_RAM_AW];

    always_ff @(posedge clk) begin
        // Old contents, write lands after the read
        q_o <= mem[req_i.addr];
        if (req_i.we) begin
            mem[req_i.addr] <= req_i.wdata;
        end
    end

endmodule

`default_nettype wire

/* design/upi_exec_core.sv */
/*
 * UPI instruction engine
 * Machine-cycle strobe, fetch/operand sequencer and accumulator datapath
 * for a reduced 8048-encoded instruction set
 */
`timescale 1ns/10ps
`default_nettype none

`include "upi_config.svh"

module upi_exec_core
    import upi_pkg::*;
(
    input  wire                    clk,
    input  wire                    rst_i,
    input  wire                    cen_i,
    output logic [`UPI_ROM_AW-1:0] rom_addr_o,
    input  wire [7:0]              rom_data_i,
    output ram_req_t               ram_req_o,
    input  wire [7:0]              ram_data_i,
    input  wire [7:0]              dbbin_i,
    input  wire                    ibf_i,
    input  wire                    obf_i,
    output logic                   dbb_rd_o,
    output logic                   dbb_wr_o,
    output logic [7:0]             dbb_wdata_o,
    input  wire [7:0]              p1_i,
    input  wire [7:0]              p2_i,
    output logic [7:0]             p1_o,
    output logic [7:0]             p2_o,
    input  wire                    t0_i,
    input  wire                    t1_i,
    output logic [7:0]             acc_o
);

    localparam int DIV_W = $clog2(`UPI_CEN_DIV);

    typedef enum logic {
        S_FETCH,
        S_OPER
    } seq_e;

    logic [DIV_W-1:0]       cen_cnt;
    logic                   mcyc_stb;
    logic                   fetch_stb;
    seq_e                   state;
    logic [`UPI_ROM_AW-1:0] pc;
    upi_op_e                ir;
    upi_op_e                op_now;
    logic [7:0]             acc;
    logic [`UPI_RAM_AW-1:0] r0;

    // Opcodes followed by an operand byte
    function automatic logic is_two_byte(input upi_op_e op);
        case (op)
            ADD_IMM, MOV_A_IMM, MOV_R0_IMM: return 1'b1;
            JNIBF, JT0, JNT0, JT1, JOBF: return 1'b1;
            JMP_P0, JMP_P1, JMP_P2, JMP_P3: return 1'b1;
            JMP_P4, JMP_P5, JMP_P6, JMP_P7: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    // Machine cycle every third enabled clk
    assign mcyc_stb = cen_i && (cen_cnt == DIV_W'(`UPI_CEN_DIV - 1));

    always_ff @(posedge clk) begin
        if (rst_i) begin
            cen_cnt <= '0;
        end else if (cen_i) begin
            if (mcyc_stb) begin
                cen_cnt <= '0;
            end else begin
                cen_cnt <= cen_cnt + 1'b1;
            end
        end
    end

    // ROM byte at pc is ready well before the next strobe
    assign op_now    = upi_op_e'(rom_data_i);
    assign fetch_stb = mcyc_stb && (state == S_FETCH);

    // Single-cycle side effects of one-byte opcodes
    assign dbb_rd_o    = fetch_stb && (op_now == IN_DBB);
    assign dbb_wr_o    = fetch_stb && (op_now == OUT_DBB);
    assign dbb_wdata_o = acc;

    // RAM always addressed by R0, read data settles within the cycle
    assign ram_req_o = '{addr: r0, wdata: acc, we: fetch_stb && (op_now == MOV_AT_R0_A)};

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state <= S_FETCH;
            pc    <= '0;
            acc   <= 8'd0;
            r0    <= '0;
            p1_o  <= 8'hFF;
            p2_o  <= 8'hFF;
        end else if (mcyc_stb) begin
            // Default step to the next byte
            pc <= pc + 1'b1;
            case (state)
                S_FETCH: begin
                    ir <= op_now;
                    if (is_two_byte(op_now)) begin
                        state <= S_OPER;
                    end
                    case (op_now)
                        IN_DBB:      acc  <= dbbin_i;
                        OUTL_P1:     p1_o <= acc;
                        OUTL_P2:     p2_o <= acc;
                        IN_P1:       acc  <= p1_i;
                        IN_P2:       acc  <= p2_i;
                        MOV_A_AT_R0: acc  <= ram_data_i;
                        // NOP, OUT_DBB, RAM write and unknowns
                        default: ;
                    endcase
                end
                S_OPER: begin
                    state <= S_FETCH;
                    case (ir)
                        ADD_IMM:    acc <= acc + rom_data_i;
                        MOV_A_IMM:  acc <= rom_data_i;
                        MOV_R0_IMM: r0  <= rom_data_i;
                        // Conditional jumps stay in the current page
                        JNIBF: if (!ibf_i) pc[7:0] <= rom_data_i;
                        JT0:   if (t0_i)   pc[7:0] <= rom_data_i;
                        JNT0:  if (!t0_i)  pc[7:0] <= rom_data_i;
                        JT1:   if (t1_i)   pc[7:0] <= rom_data_i;
                        JOBF:  if (obf_i)  pc[7:0] <= rom_data_i;
                        // Page from opcode top bits
                        JMP_P0, JMP_P1, JMP_P2, JMP_P3,
                        JMP_P4, JMP_P5, JMP_P6, JMP_P7: begin
                            pc <= {ir[7:5], rom_data_i};
                        end
                        default: ;
                    endcase
                end
                default: state <= S_FETCH;
            endcase
        end
    end

    assign rom_addr_o = pc;
    assign acc_o      = acc;

endmodule

`default_nettype wire

/* design/upi_host_port.sv */
/*
 * UPI host data bus port
 * DBBIN/DBBOUT buffers, IBF/OBF/F1 flags and strobe edge detection
 */
`timescale 1ns/10ps
`default_nettype none

module upi_host_port
    import upi_pkg::*;
(
    input  wire             clk,
    input  wire             rst_i,
    input  wire host_bus_t  host_i,
    output logic [7:0]      dout_o,
    output logic [7:0]      dbbin_o,
    output logic            ibf_o,
    output logic            obf_o,
    input  wire             dbb_rd_i,
    input  wire             dbb_wr_i,
    input  wire [7:0]       dbb_wdata_i
);

    // Previous strobe levels
    logic wr_n_q;
    logic rd_n_q;
    // DBBOUT selected during the read in progress
    logic rd_dbb_q;

    logic [7:0]  dbbin;
    logic [7:0]  dbbout;
    logic        ibf;
    logic        obf;
    logic        f1;
    upi_status_t status;

    logic wr_start;
    logic rd_done;

    // Falling wr_n while selected
    assign wr_start = !host_i.cs_n && wr_n_q && !host_i.wr_n;
    // Rising rd_n ends a DBBOUT read
    assign rd_done = !rd_n_q && host_i.rd_n && rd_dbb_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            wr_n_q   <= 1'b1;
            rd_n_q   <= 1'b1;
            rd_dbb_q <= 1'b0;
        end else begin
            wr_n_q   <= host_i.wr_n;
            rd_n_q   <= host_i.rd_n;
            rd_dbb_q <= !host_i.cs_n && !host_i.a0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ibf <= 1'b0;
            obf <= 1'b0;
            f1  <= 1'b0;
        end else begin
            // Host write beats a same-cycle IN_DBB
            if (wr_start) begin
                ibf <= 1'b1;
                f1  <= host_i.a0;
            end else if (dbb_rd_i) begin
                ibf <= 1'b0;
            end
            // OUT_DBB set wins over read completion
            if (dbb_wr_i) begin
                obf <= 1'b1;
            end else if (rd_done) begin
                obf <= 1'b0;
            end
        end
    end

    // Buffer bytes
    always_ff @(posedge clk) begin
        if (wr_start) begin
            dbbin <= host_i.din;
        end
        if (dbb_wr_i) begin
            dbbout <= dbb_wdata_i;
        end
    end

    assign status = '{user: 4'd0, f1: f1, f0: 1'b0, ibf: ibf, obf: obf};

    // Host read mux, a0 high selects status
    always_comb begin
        if (!host_i.cs_n && !host_i.rd_n) begin
            dout_o = host_i.a0 ? status : dbbout;
        end else begin
            dout_o = 8'd0;
        end
    end

    assign dbbin_o = dbbin;
    assign ibf_o   = ibf;
    assign obf_o   = obf;

endmodule

`default_nettype wire

/* design/upi_mcu.sv */
/*
 * UPI peripheral controller top level
 * Host port, instruction engine, program memory and data RAM,
 * with quasi-bidirectional port inputs and a registered debug selector
 */
`timescale 1ns/10ps
`default_nettype none

`include "upi_config.svh"

module upi_mcu
    import upi_pkg::*;
(
    input  wire                     clk,
    input  wire                     rst_i,
    input  wire                     cen_i,
    input  wire host_bus_t          host_i,
    output logic [7:0]              dout_o,
    input  wire [7:0]               p1_i,
    input  wire [7:0]               p2_i,
    output logic [7:0]              p1_o,
    output logic [7:0]              p2_o,
    input  wire                     t0_i,
    input  wire                     t1_i,
    input  wire [`UPI_ROM_AW-1:0]   prog_addr_i,
    input  wire [7:0]               prog_data_i,
    input  wire                     prom_we_i,
    input  wire [`UPI_ST_SEL_W-1:0] st_addr_i,
    output logic [7:0]              st_dout_o
);

    // Debug select codes
    localparam logic [`UPI_ST_SEL_W-1:0] ST_P1_IN  = 0;
    localparam logic [`UPI_ST_SEL_W-1:0] ST_P2_IN  = 1;
    localparam logic [`UPI_ST_SEL_W-1:0] ST_P1_OUT = 2;
    localparam logic [`UPI_ST_SEL_W-1:0] ST_P2_OUT = 3;
    localparam logic [`UPI_ST_SEL_W-1:0] ST_PC_LO  = 4;
    localparam logic [`UPI_ST_SEL_W-1:0] ST_PC_HI  = 5;
    localparam logic [`UPI_ST_SEL_W-1:0] ST_ACC    = 6;
    localparam logic [`UPI_ST_SEL_W-1:0] ST_TPINS  = 7;

    logic [`UPI_ROM_AW-1:0] rom_addr;
    logic [7:0]             rom_data;
    ram_req_t               ram_req;
    logic [7:0]             ram_data;
    logic [7:0]             dbbin;
    logic                   ibf;
    logic                   obf;
    logic                   dbb_rd;
    logic                   dbb_wr;
    logic [7:0]             dbb_wdata;
    logic [7:0]             acc;
    logic [7:0]             p1_pin;
    logic [7:0]             p2_pin;

    // Pins pulled low by either side read low
    assign p1_pin = p1_i & p1_o;
    assign p2_pin = p2_i & p2_o;

    upi_host_port upi_host_port_inst (
        .clk         (clk),
        .rst_i       (rst_i),
        .host_i      (host_i),
        .dout_o      (dout_o),
        .dbbin_o     (dbbin),
        .ibf_o       (ibf),
        .obf_o       (obf),
        .dbb_rd_i    (dbb_rd),
        .dbb_wr_i    (dbb_wr),
        .dbb_wdata_i (dbb_wdata)
    );

    upi_exec_core upi_exec_core_inst (
        .clk         (clk),
        .rst_i       (rst_i),
        .cen_i       (cen_i),
        .rom_addr_o  (rom_addr),
        .rom_data_i  (rom_data),
        .ram_req_o   (ram_req),
        .ram_data_i  (ram_data),
        .dbbin_i     (dbbin),
        .ibf_i       (ibf),
        .obf_i       (obf),
        .dbb_rd_o    (dbb_rd),
        .dbb_wr_o    (dbb_wr),
        .dbb_wdata_o (dbb_wdata),
        .p1_i        (p1_pin),
        .p2_i        (p2_pin),
        .p1_o        (p1_o),
        .p2_o        (p2_o),
        .t0_i        (t0_i),
        .t1_i        (t1_i),
        .acc_o       (acc)
    );

    upi_prog_rom upi_prog_rom_inst (
        .clk       (clk),
        .rd_addr_i (rom_addr),
        .q_o       (rom_data),
        .wr_addr_i (prog_addr_i),
        .wr_data_i (prog_data_i),
        .we_i      (prom_we_i)
    );

    upi_data_ram upi_data_ram_inst (
        .clk   (clk),
        .req_i (ram_req),
        .q_o   (ram_data)
    );

    // Debug readback, one clk behind the select
    always_ff @(posedge clk) begin
        if (rst_i) begin
            st_dout_o <= 8'd0;
        end else begin
            case (st_addr_i)
                ST_P1_IN:  st_dout_o <= p1_i;
                ST_P2_IN:  st_dout_o <= p2_i;
                ST_P1_OUT: st_dout_o <= p1_o;
                ST_P2_OUT: st_dout_o <= p2_o;
                ST_PC_LO:  st_dout_o <= rom_addr[7:0];
                ST_PC_HI:  st_dout_o <= {{(16 - `UPI_ROM_AW){1'b0}}, rom_addr[`UPI_ROM_AW-1:8]};
                ST_ACC:    st_dout_o <= acc;
                ST_TPINS:  st_dout_o <= {6'd0, t1_i, t0_i};
                default:   st_dout_o <= 8'd0;
            endcase
        end
    end

endmodule

`default_nettype wire

/* design/upi_pkg.sv */
/*
 * UPI controller shared types
 * Host bus, RAM request, status byte layout and opcode values
 */
`default_nettype none

`include "upi_config.svh"

package upi_pkg;

    // Host slave bus, strobes active low
    typedef struct packed {
        logic       a0;
        logic       cs_n;
        logic       rd_n;
        logic       wr_n;
        logic [7:0] din;
    } host_bus_t;

    // Core to data RAM
    typedef struct packed {
        logic [`UPI_RAM_AW-1:0] addr;
        logic [7:0]             wdata;
        logic                   we;
    } ram_req_t;

    // Status byte as the host reads it, bit 7 first
    typedef struct packed {
        logic [3:0] user;
        logic       f1;
        logic       f0;
        logic       ibf;
        logic       obf;
    } upi_status_t;

    // 8048 encodings of the supported subset
    typedef enum logic [7:0] {
        NOP         = 8'h00,
        ADD_IMM     = 8'h03,
        MOV_A_IMM   = 8'h23,
        IN_DBB      = 8'h22,
        OUT_DBB     = 8'h02,
        OUTL_P1     = 8'h39,
        OUTL_P2     = 8'h3A,
        IN_P1       = 8'h09,
        IN_P2       = 8'h0A,
        MOV_R0_IMM  = 8'hB8,
        MOV_AT_R0_A = 8'hA0,
        MOV_A_AT_R0 = 8'hF0,
        // JMP page in the top 3 bits
        JMP_P0      = 8'h04,
        JMP_P1      = 8'h24,
        JMP_P2      = 8'h44,
        JMP_P3      = 8'h64,
        JMP_P4      = 8'h84,
        JMP_P5      = 8'hA4,
        JMP_P6      = 8'hC4,
        JMP_P7      = 8'hE4,
        JNIBF       = 8'hD6,
        JT0         = 8'h36,
        JNT0        = 8'h26,
        JT1         = 8'h56,
        JOBF        = 8'h86
    } upi_op_e;

endpackage

`default_nettype wire

/* design/upi_prog_rom.sv */
/*
 * UPI program memory
 * Synchronous read, separate load write port
 */
`timescale 1ns/10ps
`default_nettype none

`include "upi_config.svh"

module upi_prog_rom (
    input  wire                   clk,
    input  wire [`UPI_ROM_AW-1:0] rd_addr_i,
    output logic [7:0]            q_o,
    input  wire [`UPI_ROM_AW-1:0] wr_addr_i,
    input  wire [7:0]             wr_data_i,
    input  wire                   we_i
);

    logic [7:0] mem [2**`UPI_ROM_AW];

    // Load port
    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    // Fetch byte one clk after the address
    always_ff @(posedge clk) begin
        q_o <= mem[rd_addr_i];
    end

endmodule

`default_nettype wire

/* sim.f */
+incdir+design
design/upi_pkg.sv
design/upi_host_port.sv
design/upi_prog_rom.sv
design/upi_data_ram.sv
design/upi_exec_core.sv
design/upi_mcu.sv
tb/tb_upi_mcu.sv

/* tb/tb_upi_mcu.sv */
/*
 * Testbench for the UPI peripheral controller
 * Loads a host echo program, then drives the host bus with LFSR bytes
 */
`timescale 1ns/10ps
`default_nettype none

`include "upi_config.svh"

module tb_upi_mcu
    import upi_pkg::*;
();

    // Echo program returns byte + 5A through RAM 40 and sets P2 from T0
    localparam int PROG_LEN = 25;
    localparam logic [7:0] PROG [PROG_LEN] = '{
        8'hD6, 8'h00,   // 00 JNIBF 00
        8'h22,          // 02 IN A,DBB
        8'h03, 8'h5A,   // 03 ADD A,#5A
        8'hB8, 8'h40,   // 05 MOV R0,#40
        8'hA0,          // 07 MOV @R0,A
        8'h23, 8'h00,   // 08 MOV A,#00
        8'hF0,          // 0A MOV A,@R0
        8'h02,          // 0B OUT DBB,A
        8'h39,          // 0C OUTL P1,A
        8'h36, 8'h14,   // 0D JT0 14
        8'h23, 8'hC3,   // 0F MOV A,#C3
        8'h3A,          // 11 OUTL P2,A
        8'h04, 8'h00,   // 12 JMP 000
        8'h23, 8'h3C,   // 14 MOV A,#3C
        8'h3A,          // 16 OUTL P2,A
        8'h04, 8'h00    // 17 JMP 000
    };

    logic                     clk;
    logic                     rst;
    logic                     cen;
    host_bus_t                host;
    logic [7:0]               dout;
    logic [7:0]               p1_in;
    logic [7:0]               p2_in;
    logic [7:0]               p1_out;
    logic [7:0]               p2_out;
    logic                     t0;
    logic                     t1;
    logic [`UPI_ROM_AW-1:0]   prog_addr;
    logic [7:0]               prog_data;
    logic                     prom_we;
    logic [`UPI_ST_SEL_W-1:0] st_addr;
    logic [7:0]               st_dout;

    logic [7:0] lfsr;
    logic       gate_cen;
    logic       f1_exp;
    logic [7:0] last_res;
    int         checks;
    int         errors;
    int         timeouts;

    upi_mcu upi_mcu_inst (
        .clk         (clk),
        .rst_i       (rst),
        .cen_i       (cen),
        .host_i      (host),
        .dout_o      (dout),
        .p1_i        (p1_in),
        .p2_i        (p2_in),
        .p1_o        (p1_out),
        .p2_o        (p2_out),
        .t0_i        (t0),
        .t1_i        (t1),
        .prog_addr_i (prog_addr),
        .prog_data_i (prog_data),
        .prom_we_i   (prom_we),
        .st_addr_i   (st_addr),
        .st_dout_o   (st_dout)
    );

    always #2 clk = ~clk;

    // x^8 + x^6 + x^5 + x^4 + 1
    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    task automatic take_bits(input int n, output logic [7:0] v);
        v = 8'd0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[6:0], lfsr[0]};
        end
    endtask

    // Step to just after the next rising edge and gate cen if enabled
    task automatic tick();
        logic [7:0] v;
        @(posedge clk);
        #1;
        if (gate_cen) begin
            take_bits(1, v);
            cen = v[0];
        end
    endtask

    task automatic check8(input string name, input logic [7:0] got, input logic [7:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("ERROR %s got %02h expected %02h", name, got, exp);
        end
    endtask

    task automatic host_write(input logic a0, input logic [7:0] data);
        tick();
        host.a0   = a0;
        host.din  = data;
        host.cs_n = 1'b0;
        host.wr_n = 1'b0;
        tick();
        host.cs_n = 1'b1;
        host.wr_n = 1'b1;
    endtask

    // dout is combinational from the strobes so it is sampled mid-cycle
    task automatic host_read(input logic a0, output logic [7:0] data);
        tick();
        host.a0   = a0;
        host.cs_n = 1'b0;
        host.rd_n = 1'b0;
        @(negedge clk);
        data = dout;
        tick();
        host.cs_n = 1'b1;
        host.rd_n = 1'b1;
    endtask

    task automatic draw_pins();
        logic [7:0] v;
        take_bits(1, v);
        t0 = v[0];
        take_bits(1, v);
        t1 = v[0];
    endtask

    task automatic wait_obf();
        logic [7:0] st;
        int         n;
        st = 8'd0;
        n = 0;
        while (!st[0] && n < 400) begin
            host_read(1'b1, st);
            n++;
        end
        if (!st[0]) begin
            timeouts++;
            $display("Timeout, OBF never set in the status register");
        end
    endtask

    // Back in the JNIBF loop once the program address is 0 or 1
    task automatic wait_idle();
        int n;
        n = 0;
        st_addr = 4'd4;
        tick();
        while (st_dout > 8'd1 && n < 300) begin
            tick();
            n++;
        end
        if (st_dout > 8'd1) begin
            timeouts++;
            $display("Timeout, program did not return to its polling loop");
        end
    endtask

    task automatic check_result(input logic [7:0] b);
        logic [7:0] res;
        logic [7:0] r;
        logic [7:0] st;
        res = b + 8'h5A;
        wait_obf();
        host_read(1'b0, r);
        check8("dbbout", r, res);
        // OBF cleared by the read and IBF consumed by IN A,DBB
        host_read(1'b1, st);
        check8("status", st, {4'h0, f1_exp, 3'b000});
        wait_idle();
        check8("p1_o", p1_out, res);
        check8("p2_o", p2_out, t0 ? 8'h3C : 8'hC3);
        last_res = res;
    endtask

    task automatic read_debug(input logic [`UPI_ST_SEL_W-1:0] sel, output logic [7:0] v);
        tick();
        st_addr = sel;
        @(posedge clk);
        @(negedge clk);
        v = st_dout;
    endtask

    initial begin
        logic [7:0] b;
        logic [7:0] v;
        logic [7:0] st;
        clk       = 1'b0;
        rst       = 1'b1;
        cen       = 1'b0;
        host      = '{a0: 1'b0, cs_n: 1'b1, rd_n: 1'b1, wr_n: 1'b1, din: 8'd0};
        p2_in     = 8'hFF;
        t0        = 1'b0;
        t1        = 1'b0;
        prog_addr = '0;
        prog_data = 8'd0;
        prom_we   = 1'b0;
        st_addr   = 4'hF;
        lfsr      = 8'd61;
        gate_cen  = 1'b0;
        f1_exp    = 1'b0;
        last_res  = 8'd0;
        checks    = 0;
        errors    = 0;
        timeouts  = 0;
        take_bits(8, v);
        p1_in = v;

        repeat (4) tick();
        rst = 1'b0;

        // Program goes in while cen holds the machine stopped
        for (int i = 0; i < PROG_LEN; i++) begin
            tick();
            prog_addr = i[`UPI_ROM_AW-1:0];
            prog_data = PROG[i];
            prom_we   = 1'b1;
        end
        tick();
        prom_we = 1'b0;

        @(negedge clk);
        check8("p1_o", p1_out, 8'hFF);
        check8("p2_o", p2_out, 8'hFF);
        check8("st_dout_o", st_dout, 8'h00);
        host_read(1'b1, st);
        check8("status", st, 8'h00);

        // Flags only move from the host side while the machine is stopped
        draw_pins();
        take_bits(8, b);
        host_write(1'b0, b);
        host_read(1'b1, st);
        check8("status", st, 8'h02);
        take_bits(8, b);
        host_write(1'b1, b);
        f1_exp = 1'b1;
        host_read(1'b1, st);
        check8("status", st, 8'h0A);
        repeat (30) tick();
        host_read(1'b1, st);
        check8("status", st, 8'h0A);
        cen = 1'b1;
        check_result(b);

        // One pass runs with a random clock enable
        for (int n = 0; n < 8; n++) begin
            draw_pins();
            take_bits(8, b);
            gate_cen = (n == 4);
            host_write(1'b0, b);
            f1_exp = 1'b0;
            check_result(b);
            gate_cen = 1'b0;
            cen = 1'b1;
        end

        read_debug(4'd2, v);
        check8("st_dout_o sel 2", v, last_res);
        read_debug(4'd7, v);
        check8("st_dout_o sel 7", v, {6'd0, t1, t0});
        read_debug(4'd0, v);
        check8("st_dout_o sel 0", v, p1_in);
        read_debug(4'd9, v);
        check8("st_dout_o sel 9", v, 8'h00);

        $display("Checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
